// ==== common/state_cache_pkg.sv ====
package state_cache_pkg;

    // ------------------------------
    // Table access opcodes
    // ------------------------------
    typedef enum logic [1:0] {
        TBL_READ   = 2'd0,
        TBL_INSERT = 2'd1,
        TBL_REMOVE = 2'd2
    } tbl_op_t;

    // ------------------------------
    // Delete FSM states
    // ------------------------------
    typedef enum logic [2:0] {
        DEL_IDLE    = 3'd0,
        DEL_CHECK   = 3'd1,
        DEL_REMOVE  = 3'd2,
        DEL_RELEASE = 3'd3,
        DEL_DONE    = 3'd4,
        DEL_ERROR   = 3'd5
    } delete_state_t;

endpackage

// ==== hw/table/table_arbiter.sv ====
`timescale 1ns/100ps

module table_arbiter #(
    parameter int KEY_WID = 16,
    parameter int ID_WID  = 3
) (
    input  logic                     clk,
    input  logic                     htable_srst,
    input  logic                     i_lk_req,
    input  state_cache_pkg::tbl_op_t i_lk_op,
    input  logic [KEY_WID-1:0]       i_lk_key,
    input  logic [ID_WID-1:0]        i_lk_id,
    input  logic                     i_dl_req,
    input  state_cache_pkg::tbl_op_t i_dl_op,
    input  logic [KEY_WID-1:0]       i_dl_key,
    input  logic [ID_WID-1:0]        i_dl_id,
    output logic                     o_lk_gnt,
    output logic                     o_dl_gnt,
    output logic                     o_tbl_en,
    output state_cache_pkg::tbl_op_t o_tbl_op,
    output logic [KEY_WID-1:0]       o_tbl_key,
    output logic [ID_WID-1:0]        o_tbl_id
);
    // Lookup engine held the bus in the previous cycle
    logic own_lk;

    // Lookup keeps the bus while it requests; otherwise delete wins ties
    // Delete keeps an owned bus through its priority
    always_comb begin
        o_lk_gnt = 1'b0;
        o_dl_gnt = 1'b0;
        if (own_lk && i_lk_req) begin
            o_lk_gnt = 1'b1;
        end else if (i_dl_req) begin
            o_dl_gnt = 1'b1;
        end else if (i_lk_req) begin
            o_lk_gnt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            own_lk <= 1'b0;
        end else begin
            own_lk <= o_lk_gnt;
        end
    end

    // ------------------------------
    // Table access mux
    // ------------------------------
    assign o_tbl_en  = (o_lk_gnt && i_lk_req) || (o_dl_gnt && i_dl_req);
    assign o_tbl_op  = o_dl_gnt ? i_dl_op : i_lk_op;
    assign o_tbl_key = o_dl_gnt ? i_dl_key : i_lk_key;
    assign o_tbl_id  = o_dl_gnt ? i_dl_id : i_lk_id;

endmodule

// ==== hw/table/hash_table_mem.sv ====
`timescale 1ns/100ps

module hash_table_mem #(
    parameter int KEY_WID  = 16,
    parameter int ID_WID   = 3,
    parameter int TABLE_AW = 4
) (
    input  logic                     clk,
    input  logic                     htable_srst,
    input  logic                     i_tbl_en,
    input  state_cache_pkg::tbl_op_t i_tbl_op,
    input  logic [KEY_WID-1:0]       i_tbl_key,
    input  logic [ID_WID-1:0]        i_tbl_id,
    output logic                     o_rd_valid,
    output logic [KEY_WID-1:0]       o_rd_key,
    output logic [ID_WID-1:0]        o_rd_id
);
    import state_cache_pkg::*;

    localparam int NUM_SLOTS  = 2**TABLE_AW;
    localparam int NUM_CHUNKS = KEY_WID / TABLE_AW;

    logic [NUM_SLOTS-1:0] slot_valid;
    logic [KEY_WID-1:0]   slot_key [NUM_SLOTS];
    logic [ID_WID-1:0]    slot_id  [NUM_SLOTS];
    logic [TABLE_AW-1:0]  slot;

    // Fold the key into a slot index
    always_comb begin
        slot = '0;
        for (int i = 0; i < NUM_CHUNKS; i++) begin
            slot = slot ^ i_tbl_key[i*TABLE_AW +: TABLE_AW];
        end
    end

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            slot_valid <= '0;
        end else if (i_tbl_en && (i_tbl_op == TBL_INSERT)) begin
            slot_valid[slot] <= 1'b1;
        end else if (i_tbl_en && (i_tbl_op == TBL_REMOVE)) begin
            slot_valid[slot] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_tbl_en && (i_tbl_op == TBL_INSERT)) begin
            slot_key[slot] <= i_tbl_key;
            slot_id[slot]  <= i_tbl_id;
        end
        if (i_tbl_en && (i_tbl_op == TBL_READ)) begin
            o_rd_valid <= slot_valid[slot];
            o_rd_key   <= slot_key[slot];
            o_rd_id    <= slot_id[slot];
        end
    end

endmodule

// ==== hw/lookup_engine.sv ====
`timescale 1ns/100ps

module lookup_engine #(
    parameter int KEY_WID = 16,
    parameter int ID_WID  = 3
) (
    input  logic                     clk,
    input  logic                     htable_srst,
    input  logic                     i_lookup_req,
    input  logic [KEY_WID-1:0]       i_lookup_key,
    output logic                     o_lookup_rdy,
    output logic                     o_lookup_ack,
    output logic                     o_lookup_valid,
    output logic                     o_lookup_new,
    output logic [ID_WID-1:0]        o_lookup_id,
    input  logic                     i_gnt,
    input  logic                     i_rd_valid,
    input  logic [KEY_WID-1:0]       i_rd_key,
    input  logic [ID_WID-1:0]        i_rd_id,
    input  logic                     i_alloc_avail,
    input  logic [ID_WID-1:0]        i_alloc_id,
    output logic                     o_req,
    output state_cache_pkg::tbl_op_t o_op,
    output logic [KEY_WID-1:0]       o_key,
    output logic [ID_WID-1:0]        o_id,
    output logic                     o_alloc,
    output logic [KEY_WID-1:0]       o_alloc_key
);
    import state_cache_pkg::*;

    typedef enum logic [1:0] {
        LK_IDLE  = 2'd0,
        LK_READ  = 2'd1,
        LK_CHECK = 2'd2,
        LK_RESP  = 2'd3
    } lk_state_t;

    lk_state_t          state;
    logic [KEY_WID-1:0] key_r;
    logic               res_hit;
    logic               res_new;
    logic [ID_WID-1:0]  res_id;
    logic               rd_hit;
    logic               rd_insert;

    assign rd_hit    = i_rd_valid && (i_rd_key == key_r);
    assign rd_insert = !i_rd_valid && i_alloc_avail;

    // ------------------------------
    // Sequencer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state   <= LK_IDLE;
            res_hit <= 1'b0;
            res_new <= 1'b0;
        end else begin
            case (state)
                LK_IDLE: begin
                    if (i_lookup_req) begin
                        state <= LK_READ;
                    end
                end
                LK_READ: begin
                    if (i_gnt) begin
                        state <= LK_CHECK;
                    end
                end
                LK_CHECK: begin
                    state   <= LK_RESP;
                    res_hit <= rd_hit;
                    res_new <= rd_insert;
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_lookup_rdy && i_lookup_req) begin
            key_r <= i_lookup_key;
        end
        if (state == LK_CHECK) begin
            res_id <= i_rd_id;
        end
    end

    // Grant is held from the read through the insert
    assign o_req = (state == LK_READ) || (state == LK_CHECK) || ((state == LK_RESP) && res_new);
    assign o_op  = (state == LK_RESP) ? TBL_INSERT : TBL_READ;
    assign o_key = key_r;
    assign o_id  = i_alloc_id;

    assign o_alloc     = (state == LK_RESP) && res_new;
    assign o_alloc_key = key_r;

    assign o_lookup_rdy   = (state == LK_IDLE);
    assign o_lookup_ack   = (state == LK_RESP);
    assign o_lookup_valid = res_hit || res_new;
    assign o_lookup_new   = res_new;
    assign o_lookup_id    = res_new ? i_alloc_id : res_id;

endmodule

// ==== hw/delete_engine.sv ====
`timescale 1ns/100ps

module delete_engine #(
    parameter int KEY_WID = 16,
    parameter int ID_WID  = 3
) (
    input  logic                     clk,
    input  logic                     htable_srst,
    input  logic                     i_delete_req,
    input  logic [ID_WID-1:0]        i_delete_id,
    output logic                     o_delete_rdy,
    output logic                     o_delete_ack,
    output logic                     o_delete_error,
    output logic [KEY_WID-1:0]       o_delete_key,
    input  logic                     i_gnt,
    input  logic                     i_in_use,
    input  logic [KEY_WID-1:0]       i_key,
    output logic                     o_req,
    output state_cache_pkg::tbl_op_t o_op,
    output logic [KEY_WID-1:0]       o_key,
    output logic [ID_WID-1:0]        o_id,
    output logic [ID_WID-1:0]        o_query_id,
    output logic                     o_release
);
    import state_cache_pkg::*;

    delete_state_t      state;
    delete_state_t      nxt_state;
    logic [ID_WID-1:0]  id_r;
    logic [KEY_WID-1:0] key_r;

    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state <= DEL_IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            DEL_IDLE:    nxt_state = i_delete_req ? DEL_CHECK : DEL_IDLE;
            DEL_CHECK:   nxt_state = i_in_use ? DEL_REMOVE : DEL_ERROR;
            DEL_REMOVE:  nxt_state = i_gnt ? DEL_RELEASE : DEL_REMOVE;
            DEL_RELEASE: nxt_state = DEL_DONE;
            default:     nxt_state = DEL_IDLE;
        endcase
    end

    // ID from the request, key from the reverse map
    always_ff @(posedge clk) begin
        if (o_delete_rdy && i_delete_req) begin
            id_r <= i_delete_id;
        end
        if ((state == DEL_CHECK) && i_in_use) begin
            key_r <= i_key;
        end
    end

    assign o_query_id = id_r;
    assign o_release  = (state == DEL_RELEASE);

    assign o_req = (state == DEL_REMOVE);
    assign o_op  = TBL_REMOVE;
    assign o_key = key_r;
    assign o_id  = id_r;

    assign o_delete_rdy   = (state == DEL_IDLE);
    assign o_delete_ack   = (state == DEL_DONE) || (state == DEL_ERROR);
    assign o_delete_error = (state == DEL_ERROR);
    assign o_delete_key   = key_r;

endmodule

// ==== hw/id_allocator.sv ====
`timescale 1ns/100ps

module id_allocator #(
    parameter int KEY_WID = 16,
    parameter int ID_WID  = 3
) (
    input  logic               clk,
    input  logic               htable_srst,
    input  logic               i_alloc,
    input  logic [KEY_WID-1:0] i_alloc_key,
    input  logic [ID_WID-1:0]  i_query_id,
    input  logic               i_release,
    output logic               o_alloc_avail,
    output logic [ID_WID-1:0]  o_alloc_id,
    output logic               o_query_in_use,
    output logic [KEY_WID-1:0] o_query_key,
    output logic [ID_WID:0]    o_fill
);
    localparam int NUM_IDS = 2**ID_WID;

    logic [NUM_IDS-1:0] in_use;
    logic [KEY_WID-1:0] key_store [NUM_IDS];

    // Lowest free ID wins, so scan from the top down
    always_comb begin
        o_alloc_avail = 1'b0;
        o_alloc_id    = '0;
        for (int i = NUM_IDS - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                o_alloc_avail = 1'b1;
                o_alloc_id    = ID_WID'(i);
            end
        end
    end

    // Alloc and release never touch the same ID
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            in_use <= '0;
            o_fill <= '0;
        end else begin
            if (i_release) begin
                in_use[i_query_id] <= 1'b0;
            end
            if (i_alloc) begin
                in_use[o_alloc_id] <= 1'b1;
            end
            if (i_alloc && !i_release) begin
                o_fill <= o_fill + 1'b1;
            end else if (i_release && !i_alloc) begin
                o_fill <= o_fill - 1'b1;
            end
        end
    end

    // ------------------------------
    // Reverse map
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_alloc) begin
            key_store[o_alloc_id] <= i_alloc_key;
        end
    end

    assign o_query_in_use = in_use[i_query_id];
    assign o_query_key    = key_store[i_query_id];

endmodule

// ==== hw/lookup_stats.sv ====
`timescale 1ns/100ps

module lookup_stats #(
    parameter int CNT_WID = 32
) (
    input  logic               clk,
    input  logic               htable_srst,
    input  logic               i_ack,
    input  logic               i_valid,
    input  logic               i_new,
    input  logic               i_clear,
    output logic [CNT_WID-1:0] o_cnt_req,
    output logic [CNT_WID-1:0] o_cnt_existing,
    output logic [CNT_WID-1:0] o_cnt_new,
    output logic [CNT_WID-1:0] o_cnt_not_tracked
);
    localparam int NUM_CNT = 4;

    logic [NUM_CNT-1:0] evt;
    logic [CNT_WID-1:0] cnt [NUM_CNT];

    // Outcome strobes, one per counter
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            evt <= '0;
        end else begin
            evt[0] <= i_ack;
            evt[1] <= i_ack && i_valid && !i_new;
            evt[2] <= i_ack && i_valid && i_new;
            evt[3] <= i_ack && !i_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (htable_srst || i_clear) begin
                cnt[i] <= '0;
            end else if (evt[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign o_cnt_req         = cnt[0];
    assign o_cnt_existing    = cnt[1];
    assign o_cnt_new         = cnt[2];
    assign o_cnt_not_tracked = cnt[3];

endmodule

// ==== hw/state_cache_top.sv ====
`timescale 1ns/100ps

module state_cache_top #(
    parameter int KEY_WID  = 16,
    parameter int ID_WID   = 3,
    parameter int TABLE_AW = 4,
    parameter int CNT_WID  = 32
) (
    input  logic               clk,
    input  logic               htable_srst,
    input  logic               i_lookup_req,
    input  logic [KEY_WID-1:0] i_lookup_key,
    output logic               o_lookup_rdy,
    output logic               o_lookup_ack,
    output logic               o_lookup_valid,
    output logic               o_lookup_new,
    output logic [ID_WID-1:0]  o_lookup_id,
    input  logic               i_delete_req,
    input  logic [ID_WID-1:0]  i_delete_id,
    output logic               o_delete_rdy,
    output logic               o_delete_ack,
    output logic               o_delete_error,
    output logic [KEY_WID-1:0] o_delete_key,
    input  logic               i_cnt_clear,
    output logic [CNT_WID-1:0] o_cnt_req,
    output logic [CNT_WID-1:0] o_cnt_existing,
    output logic [CNT_WID-1:0] o_cnt_new,
    output logic [CNT_WID-1:0] o_cnt_not_tracked,
    output logic [ID_WID:0]    o_fill
);
    import state_cache_pkg::*;

    // Engine requests toward the arbiter
    logic               lk_req;
    logic               lk_gnt;
    tbl_op_t            lk_op;
    logic [KEY_WID-1:0] lk_key;
    logic [ID_WID-1:0]  lk_id;
    logic               dl_req;
    logic               dl_gnt;
    tbl_op_t            dl_op;
    logic [KEY_WID-1:0] dl_key;
    logic [ID_WID-1:0]  dl_id;

    // Arbitrated table access and read data
    logic               tbl_en;
    tbl_op_t            tbl_op;
    logic [KEY_WID-1:0] tbl_key;
    logic [ID_WID-1:0]  tbl_id;
    logic               rd_valid;
    logic [KEY_WID-1:0] rd_key;
    logic [ID_WID-1:0]  rd_id;

    // Allocator side
    logic               alloc_avail;
    logic [ID_WID-1:0]  alloc_id;
    logic               alloc;
    logic [KEY_WID-1:0] alloc_key;
    logic [ID_WID-1:0]  query_id;
    logic               query_in_use;
    logic [KEY_WID-1:0] query_key;
    logic               release_id;

    lookup_engine #(.KEY_WID(KEY_WID), .ID_WID(ID_WID)) lookup_engine_i (
        .clk, .htable_srst,
        .i_lookup_req, .i_lookup_key, .o_lookup_rdy, .o_lookup_ack,
        .o_lookup_valid, .o_lookup_new, .o_lookup_id,
        .i_gnt(lk_gnt), .o_req(lk_req), .o_op(lk_op), .o_key(lk_key), .o_id(lk_id),
        .i_rd_valid(rd_valid), .i_rd_key(rd_key), .i_rd_id(rd_id),
        .i_alloc_avail(alloc_avail), .i_alloc_id(alloc_id),
        .o_alloc(alloc), .o_alloc_key(alloc_key)
    );

    delete_engine #(.KEY_WID(KEY_WID), .ID_WID(ID_WID)) delete_engine_i (
        .clk, .htable_srst,
        .i_delete_req, .i_delete_id, .o_delete_rdy, .o_delete_ack,
        .o_delete_error, .o_delete_key,
        .i_gnt(dl_gnt), .o_req(dl_req), .o_op(dl_op), .o_key(dl_key), .o_id(dl_id),
        .i_in_use(query_in_use), .i_key(query_key),
        .o_query_id(query_id), .o_release(release_id)
    );

    table_arbiter #(.KEY_WID(KEY_WID), .ID_WID(ID_WID)) table_arbiter_i (
        .clk, .htable_srst,
        .i_lk_req(lk_req), .i_lk_op(lk_op), .i_lk_key(lk_key), .i_lk_id(lk_id),
        .i_dl_req(dl_req), .i_dl_op(dl_op), .i_dl_key(dl_key), .i_dl_id(dl_id),
        .o_lk_gnt(lk_gnt), .o_dl_gnt(dl_gnt),
        .o_tbl_en(tbl_en), .o_tbl_op(tbl_op), .o_tbl_key(tbl_key), .o_tbl_id(tbl_id)
    );

    hash_table_mem #(
        .KEY_WID(KEY_WID), .ID_WID(ID_WID), .TABLE_AW(TABLE_AW)
    ) hash_table_mem_i (
        .clk, .htable_srst,
        .i_tbl_en(tbl_en), .i_tbl_op(tbl_op), .i_tbl_key(tbl_key), .i_tbl_id(tbl_id),
        .o_rd_valid(rd_valid), .o_rd_key(rd_key), .o_rd_id(rd_id)
    );

    id_allocator #(.KEY_WID(KEY_WID), .ID_WID(ID_WID)) id_allocator_i (
        .clk, .htable_srst,
        .i_alloc(alloc), .i_alloc_key(alloc_key),
        .i_query_id(query_id), .i_release(release_id),
        .o_alloc_avail(alloc_avail), .o_alloc_id(alloc_id),
        .o_query_in_use(query_in_use), .o_query_key(query_key), .o_fill
    );

    lookup_stats #(.CNT_WID(CNT_WID)) lookup_stats_i (
        .clk, .htable_srst,
        .i_ack(o_lookup_ack), .i_valid(o_lookup_valid), .i_new(o_lookup_new),
        .i_clear(i_cnt_clear),
        .o_cnt_req, .o_cnt_existing, .o_cnt_new, .o_cnt_not_tracked
    );

endmodule

// ==== verif/tb_state_cache.sv ====
`timescale 1ns/100ps

module tb_state_cache;
    localparam int KEY_WID   = 16;
    localparam int ID_WID    = 3;
    localparam int TABLE_AW  = 4;
    localparam int CNT_WID   = 32;
    localparam int NUM_IDS   = 2**ID_WID;
    localparam int NUM_SLOTS = 2**TABLE_AW;
    // Up to about 100 operations of under 10 cycles each, with a wide margin
    localparam int MAX_CYCLES = 4000;

    logic               clk;
    logic               htable_srst;
    logic               i_lookup_req;
    logic [KEY_WID-1:0] i_lookup_key;
    logic               o_lookup_rdy;
    logic               o_lookup_ack;
    logic               o_lookup_valid;
    logic               o_lookup_new;
    logic [ID_WID-1:0]  o_lookup_id;
    logic               i_delete_req;
    logic [ID_WID-1:0]  i_delete_id;
    logic               o_delete_rdy;
    logic               o_delete_ack;
    logic               o_delete_error;
    logic [KEY_WID-1:0] o_delete_key;
    logic               i_cnt_clear;
    logic [CNT_WID-1:0] o_cnt_req;
    logic [CNT_WID-1:0] o_cnt_existing;
    logic [CNT_WID-1:0] o_cnt_new;
    logic [CNT_WID-1:0] o_cnt_not_tracked;
    logic [ID_WID:0]    o_fill;

    // Reference model of table, free-ID bitmap and counters
    logic [NUM_SLOTS-1:0] m_valid;
    logic [KEY_WID-1:0]   m_key [NUM_SLOTS];
    logic [ID_WID-1:0]    m_id [NUM_SLOTS];
    logic [NUM_IDS-1:0]   m_in_use;
    logic [KEY_WID-1:0]   m_rev_key [NUM_IDS];
    logic [CNT_WID-1:0]   m_req;
    logic [CNT_WID-1:0]   m_existing;
    logic [CNT_WID-1:0]   m_new;
    logic [CNT_WID-1:0]   m_not_tracked;
    logic [ID_WID:0]      m_fill;

    logic [KEY_WID-1:0]  lk_key_q;
    logic [ID_WID-1:0]   dl_id_q;
    logic [TABLE_AW-1:0] lk_slot;
    logic                exp_valid;
    logic                exp_new;
    logic [ID_WID-1:0]   exp_id;
    logic [ID_WID:0]     exp_dl_fill;
    logic [31:0]         lfsr_state;
    int                  errors = 0;
    int                  cycles = 0;
    int                  n_lookups;
    int                  n_deletes;

    state_cache_top #(
        .KEY_WID(KEY_WID), .ID_WID(ID_WID), .TABLE_AW(TABLE_AW), .CNT_WID(CNT_WID)
    ) state_cache_top_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Model helpers
    // ------------------------------
    function automatic logic [TABLE_AW-1:0] slot_of(input logic [KEY_WID-1:0] key);
        logic [TABLE_AW-1:0] s;
        s = '0;
        for (int i = 0; i < KEY_WID / TABLE_AW; i++) begin
            s = s ^ key[i*TABLE_AW +: TABLE_AW];
        end
        return s;
    endfunction

    function automatic logic [ID_WID-1:0] lowest_free(input logic [NUM_IDS-1:0] used);
        logic [ID_WID-1:0] id;
        logic              found;
        id = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_IDS; i++) begin
            if (!found && !used[i]) begin
                id = ID_WID'(i);
                found = 1'b1;
            end
        end
        return id;
    endfunction

    // Key whose slot is currently empty, built from a random base
    function automatic logic [KEY_WID-1:0] empty_slot_key(input logic [KEY_WID-1:0] base);
        logic [TABLE_AW-1:0] s;
        logic                found;
        s = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (!found && !m_valid[i]) begin
                s = TABLE_AW'(i);
                found = 1'b1;
            end
        end
        return {base[KEY_WID-1:TABLE_AW], base[TABLE_AW-1:0] ^ slot_of(base) ^ s};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always_comb begin
        lk_slot   = slot_of(lk_key_q);
        m_fill    = (ID_WID+1)'($countones(m_in_use));
        exp_valid = 1'b0;
        exp_new   = 1'b0;
        exp_id    = lowest_free(m_in_use);
        if (m_valid[lk_slot] && (m_key[lk_slot] == lk_key_q)) begin
            exp_valid = 1'b1;
            exp_id    = m_id[lk_slot];
        end else if (!m_valid[lk_slot] && (m_fill < NUM_IDS)) begin
            exp_valid = 1'b1;
            exp_new   = 1'b1;
        end
        exp_dl_fill = m_in_use[dl_id_q] ? m_fill - 1'b1 : m_fill;
    end

    // Model follows each accepted request and each ack
    always @(posedge clk) begin
        if (htable_srst) begin
            m_valid       <= '0;
            m_in_use      <= '0;
            m_req         <= '0;
            m_existing    <= '0;
            m_new         <= '0;
            m_not_tracked <= '0;
            lk_key_q      <= '0;
            dl_id_q       <= '0;
            n_lookups     <= 0;
            n_deletes     <= 0;
        end else begin
            if (o_lookup_rdy && i_lookup_req) begin
                lk_key_q <= i_lookup_key;
            end
            if (o_delete_rdy && i_delete_req) begin
                dl_id_q <= i_delete_id;
            end
            if (o_lookup_ack && exp_new) begin
                m_valid[lk_slot]  <= 1'b1;
                m_key[lk_slot]    <= lk_key_q;
                m_id[lk_slot]     <= exp_id;
                m_in_use[exp_id]  <= 1'b1;
                m_rev_key[exp_id] <= lk_key_q;
            end
            if (o_delete_ack && m_in_use[dl_id_q]) begin
                m_in_use[dl_id_q] <= 1'b0;
                m_valid[slot_of(m_rev_key[dl_id_q])] <= 1'b0;
            end
            if (o_lookup_ack) begin
                n_lookups <= n_lookups + 1;
            end
            if (o_delete_ack) begin
                n_deletes <= n_deletes + 1;
            end
            if (i_cnt_clear) begin
                m_req         <= '0;
                m_existing    <= '0;
                m_new         <= '0;
                m_not_tracked <= '0;
            end else if (o_lookup_ack) begin
                m_req         <= m_req + 1'b1;
                m_existing    <= m_existing + CNT_WID'(exp_valid && !exp_new);
                m_new         <= m_new + CNT_WID'(exp_new);
                m_not_tracked <= m_not_tracked + CNT_WID'(!exp_valid);
            end
        end
    end

    // ------------------------------
    // Checks on the ack strobes
    // ------------------------------
    assert property (@(posedge clk) disable iff (htable_srst)
        o_lookup_ack |-> (o_lookup_valid == exp_valid) && (o_lookup_new == exp_new))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: lookup %h valid/new %b%b, expected %b%b",
                 $time, lk_key_q, o_lookup_valid, o_lookup_new, exp_valid, exp_new);
    end

    assert property (@(posedge clk) disable iff (htable_srst)
        (o_lookup_ack && exp_valid) |-> (o_lookup_id == exp_id))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: lookup %h id %0d, expected %0d",
                 $time, lk_key_q, o_lookup_id, exp_id);
    end

    // Counters settle two cycles after an ack, well before the next one
    assert property (@(posedge clk) disable iff (htable_srst)
        o_lookup_ack |-> (o_fill == m_fill) && (o_cnt_req == m_req)
                         && (o_cnt_existing == m_existing) && (o_cnt_new == m_new)
                         && (o_cnt_not_tracked == m_not_tracked))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: fill %0d counts %0d/%0d/%0d/%0d, expected %0d %0d/%0d/%0d/%0d",
                 $time, o_fill, o_cnt_req, o_cnt_existing, o_cnt_new, o_cnt_not_tracked,
                 m_fill, m_req, m_existing, m_new, m_not_tracked);
    end

    assert property (@(posedge clk) disable iff (htable_srst)
        o_delete_ack |-> (o_delete_error == !m_in_use[dl_id_q]) && (o_fill == exp_dl_fill))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: delete id %0d error %b fill %0d, expected %b %0d",
                 $time, dl_id_q, o_delete_error, o_fill, !m_in_use[dl_id_q], exp_dl_fill);
    end

    assert property (@(posedge clk) disable iff (htable_srst)
        (o_delete_ack && m_in_use[dl_id_q]) |-> (o_delete_key == m_rev_key[dl_id_q]))
    else begin
        errors = errors + 1;
        $display("mismatch at %0t: delete id %0d key %h, expected %h",
                 $time, dl_id_q, o_delete_key, m_rev_key[dl_id_q]);
    end

    // ------------------------------
    // Stimulus tasks, called on the falling edge
    // ------------------------------
    task automatic random_value(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    task automatic run_lookup(input logic [KEY_WID-1:0] key);
        while (!o_lookup_rdy) @(negedge clk);
        i_lookup_req = 1'b1;
        i_lookup_key = key;
        @(negedge clk);
        i_lookup_req = 1'b0;
        while (!o_lookup_ack) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic run_delete(input logic [ID_WID-1:0] id);
        while (!o_delete_rdy) @(negedge clk);
        i_delete_req = 1'b1;
        i_delete_id  = id;
        @(negedge clk);
        i_delete_req = 1'b0;
        while (!o_delete_ack) @(negedge clk);
        @(negedge clk);
    endtask

    // Lookup and delete accepted on the same edge
    task automatic run_both(input logic [KEY_WID-1:0] key, input logic [ID_WID-1:0] id);
        logic lk_done;
        logic dl_done;
        lk_done = 1'b0;
        dl_done = 1'b0;
        i_lookup_req = 1'b1;
        i_lookup_key = key;
        i_delete_req = 1'b1;
        i_delete_id  = id;
        @(negedge clk);
        i_lookup_req = 1'b0;
        i_delete_req = 1'b0;
        while (!(lk_done && dl_done)) begin
            lk_done = lk_done || o_lookup_ack;
            dl_done = dl_done || o_delete_ack;
            @(negedge clk);
        end
    endtask

    task automatic compare_counters();
        repeat (2) @(negedge clk);
        assert ((o_cnt_req == m_req) && (o_cnt_existing == m_existing)
                && (o_cnt_new == m_new) && (o_cnt_not_tracked == m_not_tracked)
                && (o_fill == m_fill))
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: counts %0d/%0d/%0d/%0d fill %0d, model %0d/%0d/%0d/%0d %0d",
                     $time, o_cnt_req, o_cnt_existing, o_cnt_new, o_cnt_not_tracked, o_fill,
                     m_req, m_existing, m_new, m_not_tracked, m_fill);
        end
    endtask

    initial begin : stimulus
        logic [31:0]        r;
        logic [KEY_WID-1:0] key_a;
        logic [KEY_WID-1:0] key_5;
        logic [KEY_WID-1:0] key_3;
        int                 guard;
        clk          = 1'b0;
        htable_srst  = 1'b1;
        i_lookup_req = 1'b0;
        i_lookup_key = '0;
        i_delete_req = 1'b0;
        i_delete_id  = '0;
        i_cnt_clear  = 1'b0;
        lfsr_state   = 32'h3a82_0b99;
        repeat (3) @(posedge clk);
        @(negedge clk);
        htable_srst = 1'b0;
        assert (o_lookup_rdy && o_delete_rdy && !o_lookup_ack && !o_delete_ack)
        else begin
            errors = errors + 1;
            $display("mismatch at %0t: after reset rdy %b%b ack %b%b, expected 11 00",
                     $time, o_lookup_rdy, o_delete_rdy, o_lookup_ack, o_delete_ack);
        end
        compare_counters();

        // New key, repeat hit, then a colliding key
        random_value(KEY_WID, r);
        key_a = r[KEY_WID-1:0];
        run_lookup(key_a);
        run_lookup(key_a);
        run_lookup(key_a ^ 16'h0101);

        // Fill every ID
        guard = 0;
        while ((m_fill < NUM_IDS) && (guard < 60)) begin
            random_value(KEY_WID, r);
            run_lookup(r[KEY_WID-1:0]);
            guard++;
        end
        if (m_fill < NUM_IDS) begin
            errors = errors + 1;
            $display("random keys did not fill all IDs within %0d lookups", guard);
        end
        run_lookup(m_rev_key[3]);
        random_value(KEY_WID, r);
        run_lookup(empty_slot_key(r[KEY_WID-1:0]));

        // Delete, reinsert with lowest free ID, delete of a free ID
        key_5 = m_rev_key[5];
        run_delete(3'd5);
        run_delete(3'd2);
        run_lookup(key_5);
        run_delete(3'd5);

        // Same-cycle lookup and delete
        key_3 = m_rev_key[3];
        random_value(KEY_WID, r);
        run_both(empty_slot_key(r[KEY_WID-1:0]), 3'd3);
        run_both(m_rev_key[0], 3'd3);
        run_lookup(key_3);

        // Counter clear
        compare_counters();
        i_cnt_clear = 1'b1;
        @(negedge clk);
        i_cnt_clear = 1'b0;
        compare_counters();

        // Mixed random traffic
        for (int i = 0; i < 24; i++) begin
            random_value(2, r);
            if (r[1:0] == 2'd0) begin
                random_value(ID_WID, r);
                run_delete(r[ID_WID-1:0]);
            end else begin
                random_value(KEY_WID, r);
                run_lookup(r[KEY_WID-1:0]);
            end
        end
        compare_counters();

        $display("summary: %0d lookups, %0d deletes, %0d errors", n_lookups, n_deletes, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
common/state_cache_pkg.sv
hw/table/table_arbiter.sv
hw/table/hash_table_mem.sv
hw/lookup_engine.sv
hw/delete_engine.sv
hw/id_allocator.sv
hw/lookup_stats.sv
hw/state_cache_top.sv
verif/tb_state_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_state_cache
FILELIST  := filelist.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^TEST PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
